//--- Bender.yml
package:
  name: l2_write_path

sources:
  # package first, then the design bottom up
  - verilog/l2_write_pkg.sv
  - verilog/l2_write_ctrl.sv
  - verilog/write_buffer.sv
  - verilog/write_arbiter.sv
  - verilog/l2_write_path.sv
  - target: simulation
    files:
      - dv/tb_clock.sv
      - dv/axi_write_slave.sv
      - dv/tb_l2_write_path.sv

//--- all.f
verilog/l2_write_pkg.sv
verilog/l2_write_ctrl.sv
verilog/write_buffer.sv
verilog/write_arbiter.sv
verilog/l2_write_path.sv
dv/tb_clock.sv
dv/axi_write_slave.sv
dv/tb_l2_write_path.sv

//--- dv/axi_write_slave.sv
`timescale 1ns/10ps

module axi_write_slave
    import l2_write_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  logic       aw_valid,
    input  axi_wcmd_t  aw_cmd,
    output logic       aw_ready,
    input  logic       w_valid,
    input  axi_wbeat_t w_beat,
    output logic       w_ready,
    output logic       bvalid,
    input  logic       bready
);

    logic [31:0] mem [256];
    logic [31:0] rnd;
    logic [31:0] waddr;
    logic [1:0]  dly;
    logic [1:0]  phase;
    int          i;
    int          b;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    initial begin
        rnd      = 32'h8f41_4b04;
        aw_ready = 1'b0;
        w_ready  = 1'b0;
        bvalid   = 1'b0;
        for (i = 0; i < 256; i++) begin
            mem[i] = (i * 32'h9e37_79b9) ^ 32'h5a5a_0ff0;
        end
    end

    // phase 0 waits for the address, 1 takes beats, 2 answers
    always @(posedge clk) begin
        if (!rstn) begin
            phase    <= 2'd0;
            dly      <= 2'd0;
            aw_ready <= 1'b0;
            w_ready  <= 1'b0;
            bvalid   <= 1'b0;
        end else begin
            rnd <= xorshift32(rnd);
            if (aw_valid && aw_ready) begin
                aw_ready <= 1'b0;
                waddr    <= aw_cmd.addr;
                dly      <= rnd[1:0];
                phase    <= 2'd1;
            end else if (w_valid && w_ready) begin
                w_ready <= 1'b0;
                dly     <= rnd[1:0];
                waddr   <= waddr + 32'd4;
                for (b = 0; b < 4; b++) begin
                    if (w_beat.strb[b]) begin
                        mem[waddr[9:2]][8*b +: 8] <= w_beat.data[8*b +: 8];
                    end
                end
                if (w_beat.last) begin
                    phase <= 2'd2;
                end
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
                dly    <= rnd[1:0];
                phase  <= 2'd0;
            end else if (dly != 2'd0) begin
                dly <= dly - 1'b1;
            end else begin
                case (phase)
                    2'd0: aw_ready <= aw_valid;
                    2'd1: w_ready <= w_valid;
                    default: bvalid <= 1'b1;
                endcase
            end
        end
    end

endmodule

//--- dv/tb_clock.sv
`timescale 1ns/10ps

module tb_clock #(
    parameter int period_ns    = 20,
    parameter int reset_cycles = 2
) (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // release reset off the edge, like the rest of the stimulus
    initial begin
        rstn = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #2;
        rstn = 1'b1;
    end

endmodule

//--- dv/tb_l2_write_path.sv
`timescale 1ns/10ps

module tb_l2_write_path
    import l2_write_pkg::*;
#(
    parameter int offset_width = 2
);

    localparam int words      = 1 << offset_width;
    localparam int line_w     = 32 * words;
    localparam int line_bytes = 4 * words;
    // accept plus every channel of a line write, each up to five cycles
    localparam int worst_line  = 5 * (words + 2) + 4;
    localparam int num_txn     = 18;
    localparam int cycle_limit = num_txn * worst_line * 2;

    logic              clk;
    logic              rstn;
    logic              req_w;
    l2_wreq_t          wreq;
    logic [line_w-1:0] line_data;
    logic              wr_ack;
    logic              aw_valid;
    axi_wcmd_t         aw_cmd;
    logic              aw_ready;
    logic              w_valid;
    axi_wbeat_t        w_beat;
    logic              w_ready;
    logic              bvalid;
    logic              bready;

    axi_wcmd_t   exp_aw [$];
    axi_wbeat_t  exp_w [$];
    axi_wcmd_t   exp_cmd;
    axi_wbeat_t  exp_beat;
    logic [31:0] ref_mem [256];
    logic        open_txn;
    logic        open_dma;
    int          issued = 0;
    int          responded = 0;
    int          acks = 0;
    int          err_count = 0;
    int          e0 = 0;
    int          npass = 0;
    int          nfail = 0;
    int          cycles = 0;
    int          i;
    int          k;

    tb_clock clk_gen (.*);

    l2_write_path #(
        .offset_width (offset_width)
    ) uut (.*);

    axi_write_slave mem_model (.*);

    task automatic flag_error(input string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        err_count++;
    endtask

    a_aw_hold: assert property (@(posedge clk) disable iff (!rstn)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw_cmd))
        else flag_error("aw_valid dropped or aw_cmd moved before its transfer");
    a_w_hold: assert property (@(posedge clk) disable iff (!rstn)
        w_valid && !w_ready |=> w_valid && $stable(w_beat))
        else flag_error("w_valid dropped or w_beat moved before its transfer");
    a_single: assert property (@(posedge clk) disable iff (!rstn)
        aw_valid && aw_ready |-> !open_txn)
        else flag_error("new aw transfer before the previous response");
    a_ack_req: assert property (@(posedge clk) disable iff (!rstn)
        wr_ack |-> req_w)
        else flag_error("wr_ack without a pending request");
    a_ack_once: assert property (@(posedge clk) disable iff (!rstn)
        wr_ack |=> !wr_ack)
        else flag_error("wr_ack pulsed twice for one request");
    a_dma_ack: assert property (@(posedge clk) disable iff (!rstn)
        req_w && wreq.dma |-> wr_ack == (bvalid && bready && open_dma))
        else flag_error("dma wr_ack not aligned with its response");

    // transfer monitor against the expected queues
    always @(posedge clk) begin
        if (!rstn) begin
            open_txn <= 1'b0;
            open_dma <= 1'b0;
        end else begin
            if (wr_ack) begin
                acks++;
            end
            if (aw_valid && aw_ready) begin
                open_txn <= 1'b1;
                open_dma <= (aw_cmd.len == 8'd0);
                if (exp_aw.size() == 0) begin
                    flag_error("aw transfer with no request outstanding");
                end else begin
                    exp_cmd = exp_aw.pop_front();
                    assert (aw_cmd == exp_cmd)
                        else flag_error($sformatf("aw_cmd %h, expected %h", aw_cmd, exp_cmd));
                end
            end
            if (w_valid && w_ready) begin
                if (exp_w.size() == 0) begin
                    flag_error("w transfer with no beat outstanding");
                end else begin
                    exp_beat = exp_w.pop_front();
                    assert (w_beat == exp_beat)
                        else flag_error($sformatf("w_beat %h, expected %h", w_beat, exp_beat));
                end
            end
            if (bvalid && bready) begin
                open_txn <= 1'b0;
                responded++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic issue(input l2_wreq_t req, input logic [line_w-1:0] line);
        @(posedge clk);
        #2;
        req_w     = 1'b1;
        wreq      = req;
        line_data = line;
        @(negedge clk);
        while (!wr_ack) @(negedge clk);
        @(posedge clk);
        #2;
        req_w = 1'b0;
        issued++;
    endtask

    task automatic send_line(input logic [31:0] addr, input logic [15:0] tag);
        logic [line_w-1:0] line;
        axi_wbeat_t        beat;
        int                j;
        exp_aw.push_back('{addr: addr, len: 8'(words - 1), size: 3'd2});
        for (j = 0; j < words; j++) begin
            line[32*j +: 32] = {tag, 8'(j), 8'ha5};
            beat = '{data: line[32*j +: 32], strb: 4'hf, last: (j == words - 1)};
            exp_w.push_back(beat);
            ref_mem[addr[9:2] + j] = beat.data;
        end
        issue('{addr: addr, size: 3'd2, strb: 4'hf, dma: 1'b0}, line);
    endtask

    task automatic send_dma(input logic [31:0] addr, input logic [2:0] size,
                            input logic [3:0] strb, input logic [31:0] data);
        logic [line_w-1:0] line;
        int                j;
        line       = {words{~data}};
        line[31:0] = data;
        exp_aw.push_back('{addr: addr, len: 8'd0, size: size});
        exp_w.push_back('{data: data, strb: strb, last: 1'b1});
        for (j = 0; j < 4; j++) begin
            if (strb[j]) begin
                ref_mem[addr[9:2]][8*j +: 8] = data[8*j +: 8];
            end
        end
        issue('{addr: addr, size: size, strb: strb, dma: 1'b1}, line);
    endtask

    task automatic close_test(input string name);
        int j;
        while (responded != issued) @(posedge clk);
        @(posedge clk);
        for (j = 0; j < 256; j++) begin
            assert (mem_model.mem[j] === ref_mem[j])
                else flag_error($sformatf("memory word %0d is %h, expected %h",
                                          j, mem_model.mem[j], ref_mem[j]));
        end
        assert (acks == issued && exp_aw.size() == 0 && exp_w.size() == 0)
            else flag_error($sformatf("%0d acks for %0d requests, %0d aw and %0d beats left",
                                      acks, issued, exp_aw.size(), exp_w.size()));
        if (err_count == e0) begin
            npass++;
            $display("test %s passed", name);
        end else begin
            nfail++;
            $display("test %s failed with %0d errors", name, err_count - e0);
        end
        e0 = err_count;
    endtask

    initial begin
        req_w     = 1'b0;
        wreq      = '0;
        line_data = '0;
        wait (rstn === 1'b1);
        @(negedge clk);
        assert (!aw_valid && !w_valid && !bready && !wr_ack)
            else flag_error("a channel or wr_ack is active right after reset");
        for (i = 0; i < 256; i++) begin
            ref_mem[i] = mem_model.mem[i];
        end
        close_test("reset");
        for (k = 0; k < 4; k++) begin
            send_line(32'h100 + k * line_bytes, 16'(16'hc100 + k));
        end
        close_test("line_write");
        send_dma(32'h200, 3'd0, 4'b0001, 32'h1111_11aa);
        send_dma(32'h204, 3'd1, 4'b0110, 32'h22bb_cc22);
        send_dma(32'h208, 3'd2, 4'b1111, 32'hdead_beef);
        send_dma(32'h20c, 3'd0, 4'b1000, 32'hee33_3333);
        close_test("dma_write");
        // dma lands while the burst is still in flight
        send_line(32'h300, 16'h0c4d);
        send_dma(32'h304, 3'd1, 4'b0011, 32'hbeef_cafe);
        close_test("ordering");
        for (k = 0; k < 8; k++) begin
            if (k % 2 == 0) begin
                send_line(k / 2 * line_bytes, 16'(16'h5000 + k));
            end else begin
                send_dma(k / 2 * line_bytes + 8, 3'd2, 4'(k * 5), 32'h0bad_0000 + k);
            end
        end
        close_test("back_pressure");
        $display("%0d tests passed, %0d tests failed", npass, nfail);
        if (nfail == 0 && err_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- verilog/l2_write_ctrl.sv
`timescale 1ns/10ps

module l2_write_ctrl
    import l2_write_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  logic      req_w,
    input  l2_wreq_t  wreq,
    input  logic      buf_busy,
    input  logic      aw_ready,
    input  logic      w_ready,
    input  logic      bvalid,
    output wr_state_e state
);

    wr_state_e state_nxt;
    logic      dma_pend;

    // uncached single write waiting at the cache port
    assign dma_pend = req_w && wreq.dma;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (buf_busy) begin
                    state_nxt = WRT_W;
                end else if (dma_pend) begin
                    state_nxt = DMA_AW;
                end
            end
            DMA_AW: begin
                // aw_valid is always high here
                if (aw_ready) begin
                    state_nxt = DMA_W;
                end
            end
            DMA_W: begin
                if (w_ready) begin
                    state_nxt = DMA_R;
                end
            end
            DMA_R: begin
                if (bvalid) begin
                    state_nxt = IDLE;
                end
            end
            WRT_W: begin
                // hold off dma until the burst response is done
                if (!buf_busy) begin
                    state_nxt = IDLE;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

endmodule

//--- verilog/l2_write_path.sv
`timescale 1ns/10ps

module l2_write_path
    import l2_write_pkg::*;
#(
    parameter int offset_width = 2
) (
    input  logic                           clk,
    input  logic                           rstn,
    // cache side
    input  logic                           req_w,
    input  l2_wreq_t                       wreq,
    input  logic [(32<<offset_width)-1:0]  line_data,
    output logic                           wr_ack,
    // axi side
    output logic                           aw_valid,
    output axi_wcmd_t                      aw_cmd,
    input  logic                           aw_ready,
    output logic                           w_valid,
    output axi_wbeat_t                     w_beat,
    input  logic                           w_ready,
    input  logic                           bvalid,
    output logic                           bready
);

    wr_state_e                      state;
    logic                           take;
    logic [31:0]                    take_addr;
    logic [(32<<offset_width)-1:0]  take_line;
    logic                           buf_accept;
    logic                           buf_busy;
    logic                           buf_aw_valid;
    axi_wcmd_t                      buf_cmd;
    logic                           buf_aw_ready;
    logic                           buf_w_valid;
    axi_wbeat_t                     buf_beat;
    logic                           buf_w_ready;
    logic                           buf_bvalid;
    logic                           buf_bready;

    l2_write_ctrl u_ctrl (
        .clk      (clk),
        .rstn     (rstn),
        .req_w    (req_w),
        .wreq     (wreq),
        .buf_busy (buf_busy),
        .aw_ready (aw_ready),
        .w_ready  (w_ready),
        .bvalid   (bvalid),
        .state    (state)
    );

    write_buffer #(
        .offset_width (offset_width)
    ) u_wrt (
        .clk          (clk),
        .rstn         (rstn),
        .take         (take),
        .take_addr    (take_addr),
        .take_line    (take_line),
        .buf_accept   (buf_accept),
        .buf_busy     (buf_busy),
        .buf_aw_valid (buf_aw_valid),
        .buf_cmd      (buf_cmd),
        .aw_ready     (buf_aw_ready),
        .buf_w_valid  (buf_w_valid),
        .buf_beat     (buf_beat),
        .w_ready      (buf_w_ready),
        .bvalid       (buf_bvalid),
        .buf_bready   (buf_bready)
    );

    write_arbiter #(
        .offset_width (offset_width)
    ) u_arb (
        .clk          (clk),
        .state        (state),
        .req_w        (req_w),
        .wreq         (wreq),
        .line_data    (line_data),
        .wr_ack       (wr_ack),
        .aw_valid     (aw_valid),
        .aw_cmd       (aw_cmd),
        .aw_ready     (aw_ready),
        .w_valid      (w_valid),
        .w_beat       (w_beat),
        .w_ready      (w_ready),
        .bvalid       (bvalid),
        .bready       (bready),
        .take         (take),
        .take_addr    (take_addr),
        .take_line    (take_line),
        .buf_accept   (buf_accept),
        .buf_busy     (buf_busy),
        .buf_aw_valid (buf_aw_valid),
        .buf_cmd      (buf_cmd),
        .buf_aw_ready (buf_aw_ready),
        .buf_w_valid  (buf_w_valid),
        .buf_beat     (buf_beat),
        .buf_w_ready  (buf_w_ready),
        .buf_bvalid   (buf_bvalid),
        .buf_bready   (buf_bready)
    );

endmodule

//--- verilog/l2_write_pkg.sv
package l2_write_pkg;

    // write path sequencing
    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        DMA_AW = 3'd1,
        DMA_W  = 3'd2,
        DMA_R  = 3'd3,
        WRT_W  = 3'd4
    } wr_state_e;

    // cache write request, line data travels beside it
    typedef struct packed {
        logic [31:0] addr;
        logic [2:0]  size;
        logic [3:0]  strb;
        logic        dma;
    } l2_wreq_t;

    // write address channel payload
    typedef struct packed {
        logic [31:0] addr;
        logic [7:0]  len;
        logic [2:0]  size;
    } axi_wcmd_t;

    // write data channel payload
    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } axi_wbeat_t;

    // full line bursts are always 32-bit beats
    localparam logic [2:0] line_beat_size = 3'd2;
    localparam logic [3:0] line_beat_strb = 4'hf;

endpackage

//--- verilog/write_arbiter.sv
`timescale 1ns/10ps

module write_arbiter
    import l2_write_pkg::*;
#(
    parameter int offset_width = 2
) (
    input  logic                           clk,
    input  wr_state_e                      state,
    // cache side
    input  logic                           req_w,
    input  l2_wreq_t                       wreq,
    input  logic [(32<<offset_width)-1:0]  line_data,
    output logic                           wr_ack,
    // axi side
    output logic                           aw_valid,
    output axi_wcmd_t                      aw_cmd,
    input  logic                           aw_ready,
    output logic                           w_valid,
    output axi_wbeat_t                     w_beat,
    input  logic                           w_ready,
    input  logic                           bvalid,
    output logic                           bready,
    // buffer side
    output logic                           take,
    output logic [31:0]                    take_addr,
    output logic [(32<<offset_width)-1:0]  take_line,
    input  logic                           buf_accept,
    input  logic                           buf_busy,
    input  logic                           buf_aw_valid,
    input  axi_wcmd_t                      buf_cmd,
    output logic                           buf_aw_ready,
    input  logic                           buf_w_valid,
    input  axi_wbeat_t                     buf_beat,
    output logic                           buf_w_ready,
    output logic                           buf_bvalid,
    input  logic                           buf_bready
);

    logic [31:0] dma_addr_q;
    logic [2:0]  dma_size_q;
    logic [3:0]  dma_strb_q;
    logic [31:0] dma_data_q;

    // line payload goes straight over, only the strobe is gated
    assign take_addr = wreq.addr;
    assign take_line = line_data;

    always_comb begin
        take         = 1'b0;
        wr_ack       = 1'b0;
        aw_valid     = 1'b0;
        aw_cmd       = '0;
        w_valid      = 1'b0;
        w_beat       = '0;
        bready       = 1'b0;
        buf_aw_ready = 1'b0;
        buf_w_ready  = 1'b0;
        buf_bvalid   = 1'b0;
        case (state)
            IDLE, WRT_W: begin
                take         = req_w && !wreq.dma && !buf_busy;
                wr_ack       = buf_accept;
                aw_valid     = buf_aw_valid;
                aw_cmd       = buf_cmd;
                w_valid      = buf_w_valid;
                w_beat       = buf_beat;
                bready       = buf_bready;
                buf_aw_ready = aw_ready;
                buf_w_ready  = w_ready;
                buf_bvalid   = bvalid;
            end
            DMA_AW: begin
                // cache holds the request stable until wr_ack
                aw_valid    = 1'b1;
                aw_cmd.addr = wreq.addr;
                aw_cmd.len  = 8'd0;
                aw_cmd.size = wreq.size;
            end
            DMA_W: begin
                aw_cmd.addr = dma_addr_q;
                aw_cmd.size = dma_size_q;
                w_valid     = 1'b1;
                w_beat.data = dma_data_q;
                w_beat.strb = dma_strb_q;
                w_beat.last = 1'b1;
            end
            DMA_R: begin
                aw_cmd.addr = dma_addr_q;
                aw_cmd.size = dma_size_q;
                w_beat.data = dma_data_q;
                w_beat.strb = dma_strb_q;
                bready      = 1'b1;
                // the only ack source here, buffer stays closed
                wr_ack      = bvalid;
            end
            default: begin
                wr_ack = 1'b0;
            end
        endcase
    end

    // single word capture for the data phase
    always_ff @(posedge clk) begin
        if (state == DMA_AW) begin
            dma_addr_q <= wreq.addr;
            dma_size_q <= wreq.size;
            dma_strb_q <= wreq.strb;
            dma_data_q <= line_data[31:0];
        end
    end

endmodule

//--- verilog/write_buffer.sv
`timescale 1ns/10ps

module write_buffer
    import l2_write_pkg::*;
#(
    parameter int offset_width = 2
) (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic                           take,
    input  logic [31:0]                    take_addr,
    input  logic [(32<<offset_width)-1:0]  take_line,
    output logic                           buf_accept,
    output logic                           buf_busy,
    output logic                           buf_aw_valid,
    output axi_wcmd_t                      buf_cmd,
    input  logic                           aw_ready,
    output logic                           buf_w_valid,
    output axi_wbeat_t                     buf_beat,
    input  logic                           w_ready,
    input  logic                           bvalid,
    output logic                           buf_bready
);

    localparam int line_w = 32 << offset_width;
    localparam logic [7:0] burst_len = 8'((1 << offset_width) - 1);

    typedef enum logic [1:0] {
        PH_IDLE = 2'd0,
        PH_AW   = 2'd1,
        PH_W    = 2'd2,
        PH_B    = 2'd3
    } phase_e;

    phase_e                  phase;
    logic [31:0]             addr_q;
    logic [line_w-1:0]       line_q;
    logic [offset_width-1:0] beat_cnt;
    logic                    last_beat;

    assign last_beat = &beat_cnt;

    assign buf_busy   = (phase != PH_IDLE);
    assign buf_accept = take && (phase == PH_IDLE);

    assign buf_aw_valid = (phase == PH_AW);
    assign buf_w_valid  = (phase == PH_W);
    assign buf_bready   = (phase == PH_B);

    always_comb begin
        buf_cmd      = '0;
        buf_cmd.addr = addr_q;
        buf_cmd.len  = burst_len;
        buf_cmd.size = line_beat_size;
    end

    // words leave in address order, lowest word first
    always_comb begin
        buf_beat      = '0;
        buf_beat.data = line_q[32*beat_cnt +: 32];
        buf_beat.strb = line_beat_strb;
        buf_beat.last = last_beat;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            phase    <= PH_IDLE;
            beat_cnt <= '0;
        end else begin
            case (phase)
                PH_IDLE: begin
                    if (take) begin
                        phase    <= PH_AW;
                        beat_cnt <= '0;
                    end
                end
                PH_AW: begin
                    if (aw_ready) begin
                        phase <= PH_W;
                    end
                end
                PH_W: begin
                    if (w_ready) begin
                        if (last_beat) begin
                            phase <= PH_B;
                        end else begin
                            beat_cnt <= beat_cnt + 1'b1;
                        end
                    end
                end
                PH_B: begin
                    // empty again the cycle after the response
                    if (bvalid) begin
                        phase <= PH_IDLE;
                    end
                end
                default: begin
                    phase <= PH_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (buf_accept) begin
            addr_q <= take_addr;
            line_q <= take_line;
        end
    end

endmodule
